// ==== logic/exec_pkg.sv ====
package exec_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int data_w = 32;                 // Default datapath width

    // ----------------------------------------
    // Opcodes and selects
    // ----------------------------------------
    // Code 7 is left free since the second pass-through code was dropped
    typedef enum logic [3:0] {
        op_add       = 4'd0,
        op_sub       = 4'd1,
        op_shl       = 4'd2,
        op_shr       = 4'd3,
        op_pass      = 4'd4,
        op_load_low  = 4'd5,
        op_load_high = 4'd6,
        op_cmp_eq    = 4'd8,
        op_cmp_lt    = 4'd9,
        op_cmp_gt    = 4'd10,
        op_flag_not  = 4'd11,
        op_flag_and  = 4'd12,
        op_flag_move = 4'd13,
        op_jump      = 4'd14,
        op_branch    = 4'd15
    } opcode_t;

    typedef enum logic [1:0] {
        unit_arith      = 2'd0,                 // Ripple adder
        unit_shift_load = 2'd1,                 // Shifter, pass, load
        unit_compare    = 2'd2                  // Compare, flags, branch
    } unit_sel_t;

    typedef enum logic {
        out_empty = 1'b0,
        out_full  = 1'b1
    } out_state_t;

    // ----------------------------------------
    // Channel payloads
    // ----------------------------------------
    typedef struct packed {
        opcode_t     opcode;
        logic [31:0] operand_a;
        logic [31:0] operand_b;                 // Also the shift amount
        logic [31:0] link_addr;
        logic [15:0] imm;
        logic        flag_a;
        logic        flag_b;
    } exec_req_t;

    typedef struct packed {
        logic [31:0] result;
        logic        flag;
        logic        branch_taken;
        logic [31:0] target;
    } exec_rsp_t;

endpackage

// ==== logic/ripple_adder.sv ====
`timescale 1ns/1ns

module ripple_adder #(
    parameter int DATA_W = 32
) (
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  logic              subtract,
    output logic [DATA_W-1:0] sum
);

    logic [DATA_W-1:0] b_eff;
    logic [DATA_W-1:0] carry;                   // Carry into each bit

    // Two's complement, invert b and add one through the carry-in
    assign carry[0] = subtract;

    // ----------------------------------------
    // Full-adder chain
    // ----------------------------------------
    genvar i;
    generate
        for (i = 0; i < DATA_W; i = i + 1)
        begin : g_cell
            assign b_eff[i] = b[i] ^ subtract;
            assign sum[i]   = a[i] ^ b_eff[i] ^ carry[i];

            if (i < DATA_W - 1)
            begin : g_carry
                assign carry[i+1] = (a[i] & b_eff[i])
                                  | (a[i] & carry[i])
                                  | (b_eff[i] & carry[i]);
            end
        end
    endgenerate

endmodule

// ==== logic/shift_load_unit.sv ====
`timescale 1ns/1ns

module shift_load_unit #(
    parameter int DATA_W = 32
) (
    input  logic [DATA_W-1:0]   a,
    input  logic [DATA_W-1:0]   amount,
    input  logic [DATA_W/2-1:0] imm,
    input  logic                shift_right,
    input  logic                load_high,
    input  logic                pass_a,
    input  logic                shift_load_op,
    output logic [DATA_W-1:0]   result
);

    logic [DATA_W-1:0] shifted;
    logic [DATA_W-1:0] loaded;
    logic              amount_ovf;

    // ----------------------------------------
    // Logical shifts
    // ----------------------------------------
    assign amount_ovf = (amount >= DATA_W);     // Everything shifted out

    always_comb
    begin
        if (amount_ovf)
            shifted = '0;
        else if (shift_right)
            shifted = a >> amount;
        else
            shifted = a << amount;
    end

    // ----------------------------------------
    // Half-word immediate load
    // ----------------------------------------
    always_comb
    begin
        if (load_high)
            loaded = {imm, a[DATA_W/2-1:0]};    // Keep low half
        else
            loaded = {a[DATA_W-1:DATA_W/2], imm};
    end

    always_comb
    begin
        if (pass_a)
            result = a;
        else if (shift_load_op)
            result = loaded;
        else
            result = shifted;
    end

endmodule

// ==== logic/compare_branch_unit.sv ====
`timescale 1ns/1ns

module compare_branch_unit (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  logic              flag_a,
    input  logic              flag_b,
    input  logic [31:0]       link_addr,
    input  exec_pkg::opcode_t cmp_sel,
    output logic              flag,
    output logic              branch_taken,
    output logic [31:0]       target
);
    import exec_pkg::*;

    // ----------------------------------------
    // Compares and flag logic
    // ----------------------------------------
    always_comb
    begin
        flag = 1'b0;
        case (cmp_sel)
            op_cmp_eq:    flag = (a == b);
            op_cmp_lt:    flag = (a < b);         // Unsigned
            op_cmp_gt:    flag = (a > b);
            op_flag_not:  flag = ~flag_a;
            op_flag_and:  flag = flag_a & flag_b;
            op_flag_move: flag = flag_a;
            default:      flag = 1'b0;
        endcase
    end

    // ----------------------------------------
    // Branch decision
    // ----------------------------------------
    always_comb
    begin
        branch_taken = 1'b0;
        target       = 32'h0;
        case (cmp_sel)
            op_jump:
            begin
                branch_taken = 1'b1;
                target       = link_addr;
            end
            op_branch:
            begin
                branch_taken = flag_a;
                target       = flag_a ? link_addr : 32'h0;   // Zero when not taken
            end
            default:      branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== logic/exec_control.sv ====
`timescale 1ns/1ns

module exec_control (
    input  logic                clock,
    input  logic                rst_n,
    input  exec_pkg::exec_req_t req,
    input  logic                req_valid,
    output logic                req_ready,
    output exec_pkg::exec_rsp_t rsp,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output logic                subtract,
    output logic                shift_right,
    output logic                load_high,
    output logic                pass_a,
    output exec_pkg::opcode_t   cmp_sel,
    input  logic [31:0]         sum,
    input  logic [31:0]         shift_result,
    input  logic                flag,
    input  logic                branch_taken,
    input  logic [31:0]         target
);
    import exec_pkg::*;

    unit_sel_t  unit_sel;
    out_state_t state;
    exec_rsp_t  rsp_next;
    logic       accept;

    // ----------------------------------------
    // Opcode decode
    // ----------------------------------------
    always_comb
    begin
        unit_sel    = unit_compare;             // Free codes give an all-zero response
        subtract    = 1'b0;
        shift_right = 1'b0;
        load_high   = 1'b0;
        pass_a      = 1'b0;
        cmp_sel     = op_add;                   // Compare unit idles on this
        case (req.opcode)
            op_add:       unit_sel = unit_arith;
            op_sub:
            begin
                unit_sel = unit_arith;
                subtract = 1'b1;
            end
            op_shl:       unit_sel = unit_shift_load;
            op_shr:
            begin
                unit_sel    = unit_shift_load;
                shift_right = 1'b1;
            end
            op_pass:
            begin
                unit_sel = unit_shift_load;
                pass_a   = 1'b1;
            end
            op_load_low:  unit_sel = unit_shift_load;
            op_load_high:
            begin
                unit_sel  = unit_shift_load;
                load_high = 1'b1;
            end
            op_cmp_eq, op_cmp_lt, op_cmp_gt,
            op_flag_not, op_flag_and, op_flag_move,
            op_jump, op_branch:
            begin
                unit_sel = unit_compare;
                cmp_sel  = req.opcode;
            end
            default:      unit_sel = unit_compare;
        endcase
    end

    // Unused fields stay zero per unit
    always_comb
    begin
        rsp_next = '0;
        case (unit_sel)
            unit_arith:      rsp_next.result = sum;
            unit_shift_load: rsp_next.result = shift_result;
            unit_compare:
            begin
                rsp_next.flag         = flag;
                rsp_next.branch_taken = branch_taken;
                rsp_next.target       = target;
            end
            default:         rsp_next = '0;
        endcase
    end

    // ----------------------------------------
    // Output register and handshakes
    // ----------------------------------------
    assign req_ready = (state == out_empty) || rsp_ready;   // Refill while draining
    assign accept    = req_valid && req_ready;
    assign rsp_valid = (state == out_full);

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
            state <= out_empty;
        else if (accept)
            state <= out_full;
        else if (rsp_ready)
            state <= out_empty;                 // Response left, nothing new
    end

    always_ff @(posedge clock)
    begin
        if (accept)
            rsp <= rsp_next;
    end

endmodule

// ==== logic/exec_unit_top.sv ====
`timescale 1ns/1ns

module exec_unit_top #(
    parameter int DATA_W = exec_pkg::data_w
) (
    input  logic                clock,
    input  logic                rst_n,
    input  exec_pkg::exec_req_t req,
    input  logic                req_valid,
    output logic                req_ready,
    output exec_pkg::exec_rsp_t rsp,
    output logic                rsp_valid,
    input  logic                rsp_ready
);
    import exec_pkg::*;

    logic              subtract;
    logic              shift_right;
    logic              load_high;
    logic              pass_a;
    logic              shift_load_op;
    opcode_t           cmp_sel;
    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] shift_result;
    logic              flag;
    logic              branch_taken;
    logic [31:0]       target;

    // Load codes take the half-word path instead of the shifter
    assign shift_load_op = (req.opcode == op_load_low) || (req.opcode == op_load_high);

    exec_control u_exec_control (
        .clock        (clock),
        .rst_n        (rst_n),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .rsp          (rsp),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .subtract     (subtract),
        .shift_right  (shift_right),
        .load_high    (load_high),
        .pass_a       (pass_a),
        .cmp_sel      (cmp_sel),
        .sum          (sum),
        .shift_result (shift_result),
        .flag         (flag),
        .branch_taken (branch_taken),
        .target       (target)
    );

    ripple_adder #(.DATA_W(DATA_W)) u_ripple_adder (
        .a        (req.operand_a),
        .b        (req.operand_b),
        .subtract (subtract),
        .sum      (sum)
    );

    shift_load_unit #(.DATA_W(DATA_W)) u_shift_load_unit (
        .a             (req.operand_a),
        .amount        (req.operand_b),                 // Shift amount rides on B
        .imm           (req.imm),
        .shift_right   (shift_right),
        .load_high     (load_high),
        .pass_a        (pass_a),
        .shift_load_op (shift_load_op),
        .result        (shift_result)
    );

    compare_branch_unit u_compare_branch_unit (
        .a            (req.operand_a),
        .b            (req.operand_b),
        .flag_a       (req.flag_a),
        .flag_b       (req.flag_b),
        .link_addr    (req.link_addr),
        .cmp_sel      (cmp_sel),
        .flag         (flag),
        .branch_taken (branch_taken),
        .target       (target)
    );

endmodule

// ==== verification/exec_unit_properties.sv ====
`timescale 1ns/1ns

module exec_unit_properties (
    input logic                clock,
    input logic                rst_n,
    input exec_pkg::exec_rsp_t rsp,
    input logic                rsp_valid,
    input logic                rsp_ready
);

    // ----------------------------------------
    // Output channel rules
    // ----------------------------------------
    property stall_hold;
        @(posedge clock) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp);
    endproperty

    property idle_after_reset;
        @(posedge clock) $rose(rst_n) |-> !rsp_valid;   // First edge out of reset
    endproperty

    a_stall_hold: assert property (stall_hold)
        else $error("rsp changed or rsp_valid dropped while the response was stalled");

    a_idle_after_reset: assert property (idle_after_reset)
        else $error("rsp_valid high on the first edge after reset");

endmodule

bind exec_unit_top exec_unit_properties u_exec_unit_properties (
    .clock     (clock),
    .rst_n     (rst_n),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
);

// ==== verification/exec_unit_tb.sv ====
`timescale 1ns/1ns

module exec_unit_tb;
    import exec_pkg::*;

    localparam int n_arith         = 200;
    localparam int n_shift         = 120;
    localparam int n_cmp           = 120;
    localparam int n_branch        = 60;
    localparam int n_bp            = 150;
    localparam int total_reqs      = n_arith + n_shift + n_cmp + n_branch + n_bp + 1;
    localparam int watchdog_cycles = total_reqs * 4 + 100;

    logic      clock;
    logic      rst_n;
    exec_req_t req;
    logic      req_valid;
    logic      req_ready;
    exec_rsp_t rsp;
    logic      rsp_valid;
    logic      rsp_ready;

    integer    seed       = 32'h7f6b18dc;
    integer    ready_seed = 32'h7f6b18dc;
    int        ready_mode;                      // 0 always ready, 1 random, 2 stalled
    exec_rsp_t exp_q[$];
    string     test_name;
    int        test_errors;
    int        total_errors;
    int        check_count;
    int        tests_run;
    int        sent_cnt;
    int        recv_cnt;

    exec_unit_top #(.DATA_W(data_w)) u_exec_unit_top (
        .clock     (clock),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic exec_rsp_t model_rsp(input exec_req_t r);
        exec_rsp_t m;
        m = '0;
        case (r.opcode)
            op_add:       m.result = r.operand_a + r.operand_b;
            op_sub:       m.result = r.operand_a - r.operand_b;
            op_shl:       m.result = (r.operand_b >= 32) ? 32'h0 : r.operand_a << r.operand_b[4:0];
            op_shr:       m.result = (r.operand_b >= 32) ? 32'h0 : r.operand_a >> r.operand_b[4:0];
            op_pass:      m.result = r.operand_a;
            op_load_low:  m.result = {r.operand_a[31:16], r.imm};
            op_load_high: m.result = {r.imm, r.operand_a[15:0]};
            op_cmp_eq:    m.flag = (r.operand_a == r.operand_b);
            op_cmp_lt:    m.flag = (r.operand_a < r.operand_b);
            op_cmp_gt:    m.flag = (r.operand_a > r.operand_b);
            op_flag_not:  m.flag = !r.flag_a;
            op_flag_and:  m.flag = r.flag_a && r.flag_b;
            op_flag_move: m.flag = r.flag_a;
            op_jump:
            begin
                m.branch_taken = 1'b1;
                m.target       = r.link_addr;
            end
            op_branch:
            begin
                m.branch_taken = r.flag_a;
                m.target       = r.flag_a ? r.link_addr : 32'h0;
            end
            default:      m = '0;
        endcase
        return m;
    endfunction

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    // ----------------------------------------
    // Response checker, sampled mid-cycle
    // ----------------------------------------
    always @(negedge clock)
    begin
        exec_rsp_t expected;
        if (rst_n)
        begin
            if (rsp_valid && rsp_ready)
            begin
                recv_cnt++;
                check_count++;
                assert (exp_q.size() != 0)
                else
                begin
                    note_error();
                    $display("FAIL %s: a response arrived with no request outstanding", test_name);
                end
                if (exp_q.size() != 0)
                begin
                    expected = exp_q.pop_front();
                    assert (rsp == expected)
                    else
                    begin
                        note_error();
                        $display("FAIL %s: expected %h, actual %h", test_name, expected, rsp);
                    end
                end
            end
            if (req_valid && req_ready)
            begin
                exp_q.push_back(model_rsp(req));
                sent_cnt++;
            end
        end
    end

    initial
    begin
        forever
        begin
            @(posedge clock);
            #1;
            case (ready_mode)
                0:       rsp_ready = 1'b1;
                1:       rsp_ready = ($random(ready_seed) & 1) != 0;
                default: rsp_ready = 1'b0;
            endcase
        end
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding", watchdog_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic random_req(input opcode_t op, output exec_req_t r);
        logic [31:0] tmp;
        r.opcode    = op;
        r.operand_a = $random(seed);
        r.operand_b = $random(seed);
        r.link_addr = $random(seed);
        tmp         = $random(seed);
        r.imm       = tmp[15:0];
        r.flag_a    = tmp[16];
        r.flag_b    = tmp[17];
        if ((op == op_shl || op == op_shr) && tmp[19:18] != 2'b00)
            r.operand_b = {26'h0, tmp[25:20]};  // Amounts around the width
        if (op >= op_cmp_eq && op <= op_cmp_gt && tmp[27:26] == 2'b00)
            r.operand_b = r.operand_a;
    endtask

    task automatic send_req(input exec_req_t r);
        req       = r;
        req_valid = 1'b1;
        @(negedge clock);
        while (!req_ready) @(negedge clock);
        @(posedge clock);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clock);
        @(posedge clock);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        sent_cnt    = 0;
        recv_cnt    = 0;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %0d %s: %0d requests, %0d errors", tests_run, test_name, sent_cnt,
                 test_errors);
    endtask

    task automatic run_batch(input string name, input int count, input int first,
                             input int span, input int mode);
        exec_req_t   r;
        logic [31:0] tmp;
        int          code;
        start_test(name);
        ready_mode = mode;
        for (int i = 0; i < count; i++)
        begin
            tmp  = $random(seed);
            code = first + int'(tmp % span);
            if (code == 7)
                code = 0;                       // Free code
            random_req(opcode_t'(code[3:0]), r);
            send_req(r);
        end
        drain();
        ready_mode = 0;
    endtask

    initial
    begin
        exec_req_t r;
        rst_n        = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        rsp_ready    = 1'b1;
        ready_mode   = 0;
        total_errors = 0;
        check_count  = 0;
        tests_run    = 0;
        test_name    = "init";
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;

        run_batch("arith", n_arith, 0, 2, 0);
        end_test();
        run_batch("shift_load", n_shift, 2, 5, 0);
        end_test();
        run_batch("compare_flag", n_cmp, 8, 6, 0);
        end_test();
        run_batch("jump_branch", n_branch, 14, 2, 0);
        end_test();
        run_batch("backpressure", n_bp, 0, 16, 1);
        assert (sent_cnt == n_bp && recv_cnt == n_bp)
        else
        begin
            note_error();
            $display("FAIL %s: expected %0d sent and received, actual %0d sent, %0d received",
                     test_name, n_bp, sent_cnt, recv_cnt);
        end
        end_test();

        // Reset with a stalled response in the register
        start_test("reset");
        ready_mode = 2;
        @(posedge clock);
        #1;
        random_req(op_add, r);
        send_req(r);
        rst_n = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;
        exp_q.delete();
        @(negedge clock);
        check_count += 2;
        assert (rsp_valid == 1'b0)
        else
        begin
            note_error();
            $display("FAIL %s: expected rsp_valid 0, actual %b", test_name, rsp_valid);
        end
        assert (req_ready == 1'b1)
        else
        begin
            note_error();
            $display("FAIL %s: expected req_ready 1, actual %b", test_name, req_ready);
        end
        ready_mode = 0;
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, total_errors);
        if (total_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== exec_unit.f ====
logic/exec_pkg.sv
logic/ripple_adder.sv
logic/shift_load_unit.sv
logic/compare_branch_unit.sv
logic/exec_control.sv
logic/exec_unit_top.sv
verification/exec_unit_properties.sv
verification/exec_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the execution unit testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f exec_unit.f \
		--top-module exec_unit_tb -o sim_exec_unit

# The log decides pass or fail, so a crash or missing message fails too
run: compile
	./obj_dir/sim_exec_unit > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx 'PASS: all tests' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
